// ==== build.f ====
+incdir+tests
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/stageRegs.sv
verilog/decodeCtrl.sv
verilog/executeCtrl.sv
verilog/memWbCtrl.sv
verilog/hazardUnit.sv
verilog/pipeControl.sv
tests/pipeControlTb.sv

// ==== run.sh ====
#!/bin/sh
# compiles the pipeline control testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module pipeControlTb -o simv
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if [ $simStatus -ne 0 ]; then
	echo "simulation returned status $simStatus"
	exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi

echo "pass message not found in sim.log"
exit 1

// ==== tests/controlModel.svh ====
// shadow copy of the five stage words and the two pieces of hazard state
instrWord sDec, sExe, sMem, sMemData, sFinal;
logic sStallReg;
logic sDivWait;
logic tookWord = 1'b0; // set when the word on Instruct was captured at the last edge

function automatic logic writes(instrWord w);
	casez (w[15:11])
		5'b01110, 5'b101??, 5'b1100?, 5'b1110?, 5'b11110, 5'b10011: return 1'b0;
		default: return 1'b1;
	endcase
endfunction

function automatic logic [2:0] dest(instrWord w);
	casez (w[15:11])
		5'b011??: return w[10:8];
		5'b1101?: return 3'd7;
		5'b11111: return w[7:5]; // loads write rt
		5'b1????: return w[4:2];
		default: return w[7:5];
	endcase
endfunction

function automatic logic isDivide(instrWord w);
	return w[15:11] == 5'b00011 || (w[15:11] == 5'b10000 && w[1:0] == 2'b11);
endfunction

function automatic decodeCtl expDecode(instrWord w);
	decodeCtl c;
	logic [4:0] op;
	op = w[15:11];
	c = '0;
	c.notBranchOrJump = 1'b1;
	c.nextPcSel = 1'b1;
	c.dataOut2Sel = 1'b1;
	c.setFlagD = op[1:0];
	casez (op)
		5'b101??: begin
			c.branch = 1'b1;
			c.notBranchOrJump = 1'b0;
			c.signExtSel = 2'b01;
		end
		5'b11000, 5'b11010: begin
			c.jump = 1'b1;
			c.notBranchOrJump = 1'b0;
			c.signExtSel = 2'b10;
			c.branchImmedSel = 1'b1;
		end
		5'b11001, 5'b11011: begin
			c.jump = 1'b1;
			c.notBranchOrJump = 1'b0;
			c.signExtSel = 2'b01;
			c.nextPcSel = 1'b0;
		end
		5'b0111?: begin
			c.signExtSel = 2'b11;
			c.zeroExtend8 = 1'b1;
		end
		5'b0110?, 5'b1111?: c.signExtSel = 2'b01;
		5'b100??: c.dataOut2Sel = 1'b0;
		default: ;
	endcase
	c.loadR7 = op[4:1] == 4'b1101; // jump and link
	return c;
endfunction

function automatic executeCtl expExecute(instrWord w);
	executeCtl c;
	logic [4:0] op;
	logic [1:0] fn;
	op = w[15:11];
	fn = w[1:0];
	c = '0;
	c.addMode = 1'b1;
	c.setFlagE = fn;
	c.shiftMode = fn;
	casez (op)
		5'b00001: c.addMode = 1'b0;
		5'b00010: c.aluOp = 3'd2;
		5'b00011: c.aluOp = 3'd3;
		5'b00100: c.aluOp = 3'd4;
		5'b00101: c.aluOp = 3'd5;
		5'b00110: c.aluOp = 3'd6;
		5'b010??: begin
			c.aluOp = 3'd1;
			c.shiftMode = op[1:0];
		end
		5'b01101: c.aluOp = 3'd5;
		5'b10000: begin
			if (fn == 2'b10)
				c.aluOp = 3'd2;
			else if (fn == 2'b11)
				c.aluOp = 3'd3;
			c.addMode = fn != 2'b01;
		end
		5'b10001: begin
			c.aluOp = {1'b1, fn};
			c.aOp[0] = fn == 2'b11;
		end
		5'b10010: c.aluOp = 3'd1;
		5'b10011: begin
			c.flagMux = 1'b1;
			c.addMode = fn == 2'b11;
		end
		default: ;
	endcase
	if (op[4:2] == 3'b011)
		c.aOp = {1'b1, op != 5'b01101};
	c.zeroB = op[4:2] == 3'b101 || op[4:1] == 4'b1101;
	return c;
endfunction

function automatic memWbCtl expMemWb();
	memWbCtl c;
	c.wrMemEn = sMem[14:11] == 4'b1110;
	c.memToReg = sMemData[14:11] == 4'b1111;
	c.wrRegEn = writes(sFinal);
	c.wrRegAddr = dest(sFinal);
	return c;
endfunction

function automatic logic hits(instrWord producer, logic [2:0] r);
	return writes(producer) && dest(producer) == r;
endfunction

function automatic fwdSel youngest(logic h4, logic h5, logic h6, logic memLoad);
	if (h4)
		return memLoad ? fromMemData : fromMemStage;
	if (h5)
		return fromWbStage;
	if (h6)
		return fromFinalStage;
	return fromMemStage;
endfunction

function automatic logic rsUsed(instrWord w);
	casez (w[15:11])
		5'b01100, 5'b01111, 5'b11000, 5'b11010, 5'b1110?, 5'b101??: return 1'b0;
		default: return 1'b1;
	endcase
endfunction

function automatic logic bjUsesRs(instrWord w);
	return w[15:13] == 3'b101 || (w[15:13] == 3'b110 && w[11]);
endfunction

function automatic forwardCtl expForward();
	forwardCtl c;
	logic memLoad;
	logic [2:0] rs, rt;
	memLoad = sMem[14:11] == 4'b1111;
	rs = sExe[10:8];
	rt = sExe[7:5];
	c.rsForwardSel = youngest(hits(sMem, rs), hits(sMemData, rs), hits(sFinal, rs), memLoad);
	c.rtForwardSel = youngest(hits(sMem, rt), hits(sMemData, rt), hits(sFinal, rt), memLoad);
	c.forwardRs = rsUsed(sExe) && (hits(sMem, rs) || hits(sMemData, rs) || hits(sFinal, rs));
	c.forwardRt = sExe[15:13] == 3'b100 &&
		(hits(sMem, rt) || hits(sMemData, rt) || hits(sFinal, rt));
	if (bjUsesRs(sDec) && (hits(sMem, sDec[10:8]) || hits(sMemData, sDec[10:8])))
		c.bjForwardSel = youngest(hits(sMem, sDec[10:8]), hits(sMemData, sDec[10:8]),
			1'b0, memLoad);
	else
		c.bjForwardSel = fromFinalStage;
	return c;
endfunction

function automatic logic loadUseNow();
	return sMem[14:11] == 4'b1111 && ((rsUsed(sExe) && hits(sMem, sExe[10:8])) ||
		(sExe[15:13] == 3'b100 && hits(sMem, sExe[7:5])));
endfunction

function automatic logic stallNow();
	return (loadUseNow() ^ sStallReg) || (isDivide(sExe) && !sDivWait);
endfunction

function automatic logic fetchStallNow();
	return bjUsesRs(sDec) && hits(sExe, sDec[10:8]);
endfunction

function automatic logic haltNow();
	return sDec == 16'hE000;
endfunction

task automatic resetModel();
	sDec = 16'hE800;
	sExe = 16'hE800;
	sMem = 16'hE800;
	sMemData = 16'hE800;
	sFinal = 16'hE800;
	sStallReg = 1'b0;
	sDivWait = 1'b0;
	tookWord = 1'b0;
endtask

// one rising edge of the pipe, with the inputs seen at that edge
task automatic advanceModel(instrWord word, logic ready);
	logic st, fs, hl, lu, dv;
	st = stallNow();
	fs = fetchStallNow();
	hl = haltNow();
	lu = loadUseNow();
	dv = isDivide(sExe);
	tookWord = !st && !fs && !hl;
	if (hl || !st) begin
		sFinal = sMemData;
		sMemData = sMem;
		sMem = sExe;
		if (hl)
			sExe = sDec;
		else if (fs)
			sExe = 16'hE800;
		else begin
			sExe = sDec;
			sDec = word;
		end
	end
	if (lu)
		sStallReg = st;
	if (!sDivWait)
		sDivWait = dv && ready;
	else if (!st)
		sDivWait = 1'b0;
endtask

// ==== tests/pipeControlTb.sv ====
`timescale 1ns/100ps

module pipeControlTb import isaPkg::*, ctrlPkg::*; ();

	localparam int randomCount = 40;
	localparam int progLimit = 30 + randomCount + 1; // script, random words and the halt
	localparam int timeLimit = (progLimit * 6 + 40) * 40; // worst case stall per word

	logic clk;
	logic rst;
	instrWord Instruct;
	logic divReady;
	decodeCtl decode;
	executeCtl execute;
	memWbCtl memWb;
	forwardCtl forward;
	logic Stall, FetchStall, Halt;

	int seed = 32'hcc39_b1bd;
	int checksDone = 0;
	int divDelay = 0;
	instrWord prog[$];

	`include "controlModel.svh"

	pipeControl pipeControl_inst (
		.clk, .rst, .Instruct, .divReady, .decode, .execute, .memWb, .forward,
		.Stall, .FetchStall, .Halt
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic checkField(string name, logic [15:0] got, logic [15:0] exp);
		checksDone++;
		assert (got === exp) else begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "output mismatch");
		end
	endtask

	// outputs are read before the edge updates anything, then the model steps
	always @(posedge clk) begin
		if (rst) begin
			resetModel();
		end else begin
			checkField("decode", 16'(decode), 16'(expDecode(sDec)));
			checkField("execute", 16'(execute), 16'(expExecute(sExe)));
			checkField("memWb", 16'(memWb), 16'(expMemWb()));
			checkField("forward", 16'(forward), 16'(expForward()));
			checkField("Stall", 16'(Stall), 16'(stallNow()));
			checkField("FetchStall", 16'(FetchStall), 16'(fetchStallNow()));
			checkField("Halt", 16'(Halt), 16'(haltNow()));
			advanceModel(Instruct, divReady);
		end
	end

	task automatic randomAluWord(output instrWord w);
		int k;
		int raw;
		k = int'($unsigned($random(seed)) % 8);
		raw = $random(seed);
		w = raw[15:0];
		case (k)
			0: w[15:11] = 5'b00000;
			1: w[15:11] = 5'b00001;
			2: w[15:11] = 5'b00010;
			3: w[15:11] = 5'b00100;
			4: w[15:11] = 5'b00101;
			5: w[15:11] = 5'b10000;
			6: w[15:11] = 5'b10001;
			default: w[15:11] = 5'b10010;
		endcase
		if (k == 5 && w[1:0] == 2'b11)
			w[1:0] = 2'b00; // keep register divides out of the random part
	endtask

	task automatic buildProgram();
		instrWord w;
		// independent words of each class
		prog = '{16'h0145, 16'h8394, 16'hA608, 16'hC010, 16'h6105, 16'hD020,
			16'hF141, 16'h4C43, 16'h9B28};
		prog.push_back(16'h8394); // back to back dependent ALU words
		prog.push_back(16'h85B8);
		prog.push_back(16'h8EBD);
		prog.push_back(16'hF962); // load into r3 and then its user
		prog.push_back(16'h8348);
		prog.push_back(16'h1A83); // immediate divide
		prog.push_back(16'h8394);
		prog.push_back(16'h8117); // register divide
		prog.push_back(16'h0145); // writer of r2, then a register branch on r2
		prog.push_back(16'hAA04);
		prog.push_back(16'h8394);
		repeat (randomCount) begin
			randomAluWord(w);
			prog.push_back(w);
		end
		prog.push_back(16'hE000);
	endtask

	// divReady comes back a random number of cycles after a divide reaches execute
	task automatic driveDivReady();
		if (isDivide(sExe) && !sDivWait) begin
			if (divDelay == 0) begin
				divReady = 1'b1;
			end else begin
				divReady = 1'b0;
				divDelay--;
			end
		end else begin
			divReady = 1'b0;
			divDelay = int'($unsigned($random(seed)) % 4);
		end
	endtask

	initial begin
		int idx;
		rst = 1'b1;
		Instruct = 16'hE800;
		divReady = 1'b0;
		idx = 0;
		buildProgram();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (idx < prog.size()) begin
			Instruct = prog[idx];
			driveDivReady();
			@(negedge clk);
			if (tookWord)
				idx++;
		end
		Instruct = 16'hE800;
		repeat (8) begin
			driveDivReady();
			@(negedge clk);
		end
		if (checksDone > 0 && Halt) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("the run ended without checks or without reaching halt");
			$display("Simulation finished: FAIL");
			$fatal(1, "run incomplete");
		end
	end

	initial begin
		#(timeLimit);
		$display("the run timed out before the program finished");
		$display("Simulation finished: FAIL");
		$fatal(1, "timeout");
	end

endmodule

// ==== verilog/pipeControl.sv ====
`timescale 1ns/100ps

module pipeControl import isaPkg::*, ctrlPkg::*; (
	input logic clk,
	input logic rst,
	input instrWord Instruct,
	input logic divReady,
	output decodeCtl decode,
	output executeCtl execute,
	output memWbCtl memWb,
	output forwardCtl forward,
	output logic Stall,
	output logic FetchStall,
	output logic Halt
);

	instrWord decodeWord, execWord, memWord, memDataWord, finalWord;
	logic divStart;

	stageRegs stageRegs_inst (
		.clk, .rst, .Instruct, .Stall, .FetchStall, .Halt,
		.decodeWord, .execWord, .memWord, .memDataWord, .finalWord
	);

	decodeCtrl decodeCtrl_inst (.decodeWord, .decode);

	executeCtrl executeCtrl_inst (.execWord, .execute, .divStart);

	memWbCtrl memWbCtrl_inst (.memWord, .memDataWord, .finalWord, .memWb);

	hazardUnit hazardUnit_inst (
		.clk, .rst, .execWord, .decodeWord, .memWord, .divStart, .divReady,
		.Halt, .Stall, .FetchStall, .forward
	);

endmodule

// ==== verilog/hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit import isaPkg::*, ctrlPkg::*; (
	input logic clk,
	input logic rst,
	input instrWord execWord,
	input instrWord decodeWord,
	input instrWord memWord,
	input logic divStart,
	input logic divReady,
	input logic Halt,
	output logic Stall,
	output logic FetchStall,
	output forwardCtl forward
);

	logic validDest4, validDest5, validDest6;
	regAddr dest4, dest5, dest6;
	regAddr execRs, execRt, decRs;
	opField execOp, decOp;
	logic [2:0] rsHit, rtHit, bjHit; // bit 0 is stage 4, bit 2 is stage 6
	logic rsEnable, rtEnable, bjRegEnable;
	logic loadInMem, loadUse, stallReg, divStall;
	divPhase phase;

	// youngest matching stage wins
	function automatic fwdSel pickSel(logic [2:0] hit, logic memLoad);
		if (hit[0] && memLoad)
			return fromMemData;
		else if (hit[0])
			return fromMemStage;
		else if (hit[1])
			return fromWbStage;
		else if (hit[2])
			return fromFinalStage;
		else
			return fromMemStage;
	endfunction

	assign execOp = opOf(execWord);
	assign decOp = opOf(decodeWord);
	assign execRs = rsOf(execWord);
	assign execRt = rtOf(execWord);
	assign decRs = rsOf(decodeWord);

	// destinations follow the words, a halt drains them along with the stages
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			validDest4 <= 1'b0;
			validDest5 <= 1'b0;
			validDest6 <= 1'b0;
			dest4 <= '0;
			dest5 <= '0;
			dest6 <= '0;
		end else if (Halt || !Stall) begin
			validDest4 <= writesReg(execWord);
			validDest5 <= validDest4;
			validDest6 <= validDest5;
			dest4 <= destOf(execWord);
			dest5 <= dest4;
			dest6 <= dest5;
		end
	end

	assign rsEnable = execOp != 5'b01100 && execOp != 5'b01111 && execOp != 5'b11000 &&
		execOp != 5'b11010 && execOp[4:1] != 4'b1110 && execOp[4:2] != 3'b101;
	assign rtEnable = execOp[4:2] == 3'b100; // only register format ALU words read rt here
	assign bjRegEnable = decOp[4:2] == 3'b101 || (decOp[4:2] == 3'b110 && decOp[0]);

	assign rsHit = {validDest6 && execRs == dest6, validDest5 && execRs == dest5,
		validDest4 && execRs == dest4};
	assign rtHit = {validDest6 && execRt == dest6, validDest5 && execRt == dest5,
		validDest4 && execRt == dest4};
	assign bjHit = {1'b0, validDest5 && decRs == dest5, validDest4 && decRs == dest4};

	assign loadInMem = isLoad(memWord);

	always_comb begin
		forward.forwardRs = rsEnable && |rsHit;
		forward.forwardRt = rtEnable && |rtHit;
		forward.rsForwardSel = pickSel(rsHit, loadInMem);
		forward.rtForwardSel = pickSel(rtHit, loadInMem);
		if (bjRegEnable && |bjHit)
			forward.bjForwardSel = pickSel(bjHit, loadInMem);
		else
			forward.bjForwardSel = fromFinalStage;
	end

	// the branch needs rs in decode, and the writer still sits in execute
	assign FetchStall = bjRegEnable && writesReg(execWord) && destOf(execWord) == decRs;

	assign loadUse = loadInMem && ((rsEnable && rsHit[0]) || (rtEnable && rtHit[0]));

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			stallReg <= 1'b0;
		else if (loadUse)
			stallReg <= Stall; // flips so the load-use stall lasts one cycle
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= divIdle;
		end else begin
			case (phase)
				divIdle: if (divStart && divReady) phase <= divWait;
				divWait: if (!Stall) phase <= divIdle;
				default: phase <= divIdle;
			endcase
		end
	end

	assign divStall = divStart && phase == divIdle;
	assign Stall = (loadUse ^ stallReg) | divStall;

	// the pipe comes out of reset full of NOPs, so nothing may stall at once
	quietAfterReset: assert property (
		@(posedge clk) $fell(rst) |-> !Stall && !FetchStall
	);

	// the stalled words stay put so the toggle releases the stall after one cycle
	loadUseOneCycle: assert property (
		@(posedge clk) disable iff (rst)
			loadUse && !stallReg && !divStall && !Halt |=> !Stall
	);

endmodule

// ==== verilog/memWbCtrl.sv ====
`timescale 1ns/100ps

module memWbCtrl import isaPkg::*, ctrlPkg::*; (
	input instrWord memWord,
	input instrWord memDataWord,
	input instrWord finalWord,
	output memWbCtl memWb
);

	// each field comes from the stage whose timing it has to meet
	always_comb begin
		memWb.wrMemEn = isStore(memWord);
		memWb.memToReg = isLoad(memDataWord); // picks the read data over the ALU result
		memWb.wrRegEn = writesReg(finalWord);
		memWb.wrRegAddr = destOf(finalWord);
	end

endmodule

// ==== verilog/executeCtrl.sv ====
`timescale 1ns/100ps

module executeCtrl import isaPkg::*, ctrlPkg::*; (
	input instrWord execWord,
	output executeCtl execute,
	output logic divStart
);

	opField op;
	logic [1:0] fn;

	assign op = opOf(execWord);
	assign fn = execWord[1:0];

	// the first matching row wins, register format rows use the function bits
	always_comb begin
		casez ({op, fn})
			7'b00010zz: execute.aluOp = 3'b010;
			7'b00011zz: execute.aluOp = 3'b011;
			7'b00100zz: execute.aluOp = 3'b100;
			7'b00101zz: execute.aluOp = 3'b101;
			7'b00110zz: execute.aluOp = 3'b110;
			7'b010zzzz: execute.aluOp = 3'b001; // immediate shifts
			7'b01101zz: execute.aluOp = 3'b101;
			7'b1000010: execute.aluOp = 3'b010;
			7'b1000011: execute.aluOp = 3'b011;
			7'b1000100: execute.aluOp = 3'b100;
			7'b1000101: execute.aluOp = 3'b101;
			7'b1000110: execute.aluOp = 3'b110;
			7'b1000111: execute.aluOp = 3'b111;
			7'b10010zz: execute.aluOp = 3'b001;
			default: execute.aluOp = 3'b000;
		endcase
	end

	always_comb begin
		// subtract for the immediate subtract, register subtract and the compares
		execute.addMode = !(op == 5'b00001 || (op == 5'b10000 && fn == 2'b01) ||
			(op == 5'b10011 && fn != 2'b11));

		execute.shiftMode = (op[4:2] == 3'b010) ? op[1:0] : fn;
		execute.setFlagE = fn;

		execute.aOp[0] = op == 5'b01100 || op[4:1] == 4'b0111 ||
			(op == 5'b10001 && fn == 2'b11);
		execute.aOp[1] = op[4:2] == 3'b011;

		execute.zeroB = op[4:2] == 3'b101 || op[4:1] == 4'b1101;
		execute.flagMux = op == 5'b10011;
	end

	assign divStart = op == 5'b00011 || (op == 5'b10000 && fn == 2'b11);

endmodule

// ==== verilog/decodeCtrl.sv ====
`timescale 1ns/100ps

module decodeCtrl import isaPkg::*, ctrlPkg::*; (
	input instrWord decodeWord,
	output decodeCtl decode
);

	opField op;
	logic isBranch;
	logic isJump;
	logic jumpReg;
	logic jumpImm;

	assign op = opOf(decodeWord);

	assign isBranch = op[4:2] == 3'b101;
	assign isJump = op[4:2] == 3'b110;
	assign jumpReg = isJump && op[0]; // register jumps take rs plus an offset
	assign jumpImm = isJump && !op[0];

	always_comb begin
		decode.notBranchOrJump = !(isBranch || isJump);
		decode.branch = isBranch;
		decode.jump = isJump;

		// 00 five bit, 01 eight bit, 10 eleven bit, 11 eight bit shifted into the upper byte
		decode.signExtSel[0] = op[4:2] == 3'b011 || isBranch || jumpReg ||
			op[4:1] == 4'b1111;
		decode.signExtSel[1] = op[4:1] == 4'b0111 || jumpImm;
		decode.zeroExtend8 = op[4:1] == 4'b0111;

		decode.nextPcSel = !jumpReg;
		decode.branchImmedSel = jumpImm;
		decode.loadR7 = op[4:1] == 4'b1101;
		decode.dataOut2Sel = op[4:2] != 3'b100; // register format reads rt from the file
		decode.setFlagD = op[1:0];
	end

endmodule

// ==== verilog/stageRegs.sv ====
`timescale 1ns/100ps

module stageRegs import isaPkg::*; (
	input logic clk,
	input logic rst,
	input instrWord Instruct,
	input logic Stall,
	input logic FetchStall,
	output logic Halt,
	output instrWord decodeWord,
	output instrWord execWord,
	output instrWord memWord,
	output instrWord memDataWord,
	output instrWord finalWord
);

	// finalWord only exists to line the register write up with the writeback timing
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			decodeWord <= nopWord;
			execWord <= nopWord;
			memWord <= nopWord;
			memDataWord <= nopWord;
			finalWord <= nopWord;
		end else if (Halt) begin
			execWord <= decodeWord; // halt copies drain the back of the pipe
			memWord <= execWord;
			memDataWord <= memWord;
			finalWord <= memDataWord;
		end else if (Stall) begin
			decodeWord <= decodeWord; // every stage holds
		end else if (FetchStall) begin
			execWord <= nopWord;
			memWord <= execWord;
			memDataWord <= memWord;
			finalWord <= memDataWord;
		end else begin
			decodeWord <= Instruct;
			execWord <= decodeWord;
			memWord <= execWord;
			memDataWord <= memWord;
			finalWord <= memDataWord;
		end
	end

	assign Halt = decodeWord == haltWord;

endmodule

// ==== verilog/ctrlPkg.sv ====
package ctrlPkg;
	import isaPkg::*;

	typedef logic [2:0] aluOp;
	typedef logic [1:0] extSel;
	typedef logic [1:0] flagCode;
	typedef logic [1:0] shiftCode;
	typedef logic [1:0] aSel;

	// where a forwarded operand is taken from
	typedef enum logic [1:0] {
		fromMemStage = 2'b00,
		fromMemData = 2'b01,
		fromWbStage = 2'b10,
		fromFinalStage = 2'b11
	} fwdSel;

	typedef struct packed {
		logic notBranchOrJump;
		extSel signExtSel;
		logic zeroExtend8;
		logic nextPcSel;
		logic branchImmedSel;
		logic loadR7;
		logic dataOut2Sel;
		flagCode setFlagD;
		logic branch;
		logic jump;
	} decodeCtl;

	typedef struct packed {
		aluOp aluOp;
		logic addMode;
		shiftCode shiftMode;
		flagCode setFlagE;
		aSel aOp;
		logic zeroB;
		logic flagMux;
	} executeCtl;

	typedef struct packed {
		logic wrMemEn;
		logic memToReg;
		logic wrRegEn;
		regAddr wrRegAddr;
	} memWbCtl;

	typedef struct packed {
		logic forwardRs;
		logic forwardRt;
		fwdSel rsForwardSel;
		fwdSel rtForwardSel;
		fwdSel bjForwardSel;
	} forwardCtl;

	typedef enum logic {divIdle, divWait} divPhase;
endpackage

// ==== verilog/isaPkg.sv ====
package isaPkg;
	typedef logic [15:0] instrWord;
	typedef logic [2:0] regAddr;
	typedef logic [4:0] opField;

	// low bit of each field inside the word
	localparam int opPos = 11;
	localparam int rsPos = 8;
	localparam int rtPos = 5;
	localparam int rdPos = 2;

	localparam instrWord nopWord = 16'hE800;
	localparam instrWord haltWord = 16'hE000;

	function automatic opField opOf(instrWord w);
		return w[opPos +: 5];
	endfunction

	function automatic regAddr rsOf(instrWord w);
		return w[rsPos +: 3];
	endfunction

	function automatic regAddr rtOf(instrWord w);
		return w[rtPos +: 3];
	endfunction

	function automatic regAddr rdOf(instrWord w);
		return w[rdPos +: 3];
	endfunction

	function automatic logic isLoad(instrWord w);
		return &w[14:11];
	endfunction

	function automatic logic isStore(instrWord w);
		return w[14:11] == 4'b1110;
	endfunction

	function automatic logic writesReg(instrWord w);
		opField op;
		op = opOf(w);
		return !(op == 5'b01110 || op[4:2] == 3'b101 || op[4:1] == 4'b1100 ||
			op[4:1] == 4'b1110 || op == 5'b11110 || op == 5'b10011);
	endfunction

	function automatic regAddr destOf(instrWord w);
		opField op;
		op = opOf(w);
		if (op[4:2] == 3'b011)
			return rsOf(w); // load-immediate and load-upper write back into rs
		else if (op[4:1] == 4'b1101)
			return 3'd7; // link register
		else if (op[4] && op != 5'b11111)
			return rdOf(w);
		else
			return rtOf(w);
	endfunction
endpackage
